/* sources.f */
+incdir+.
cpuPkg.sv
regFile.sv
aluFlags.sv
pcUnit.sv
ioBusMaster.sv
cpuControl.sv
cpuTop.sv
tbClock.sv
tbCpu.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tbCpu -Mdir obj_dir -o vsim
	./obj_dir/vsim | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

/* tbCpu.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module tbCpu;
    logic        clk;
    logic        arstN;
    logic        rstReq;
    logic [7:0]  iAddr;
    logic        iRead;
    logic [15:0] iData;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [7:0]  wbAdr;
    logic [7:0]  wbDatO;
    logic [7:0]  wbDatI;
    logic        wbAck;
    logic        halted;
    logic [15:0] mem [256];     // instruction memory model
    logic [7:0]  regM [8];      // register model
    logic        cM;
    logic        zM;
    logic        nM;
    logic [15:0] expOut [$];    // {port, data} expected per OUT
    logic [15:0] outLog [$];    // {port, data} seen on the bus
    logic [15:0] rdLog [$];     // {port, data} returned to IN
    logic [16:0] lfsr = 17'd89837;
    logic        slvBusy;
    logic [1:0]  slvWait;
    int          pc;
    int          errors;
    int          checks;

    tbClock u_clk (.clk, .arstN, .rstReq);

    cpuTop u_dut (.clk, .arstN, .iAddr, .iRead, .iData, .wbCyc, .wbStb, .wbWe, .wbAdr,
                  .wbDatO, .wbDatI, .wbAck, .halted);

    // taps x^17 and x^14
    // one step per bit
    function automatic logic [7:0] randBits(input int n);
        logic [7:0] r;
        logic       fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[16] ^ lfsr[13];
            lfsr = {lfsr[15:0], fb};
            r    = {r[6:0], fb};
        end
        return r;
    endfunction

    // **************************************************
    // memory and Wishbone slave models
    always @(posedge clk) begin
        if (iRead) begin
            iData <= mem[iAddr];        // one cycle latency
        end
    end

    always @(posedge clk) begin
        if (!arstN) begin
            slvBusy <= 1'b0;
            wbAck   <= 1'b0;
        end else if (wbAck) begin
            wbAck <= 1'b0;              // single cycle ack
        end else if (wbCyc && wbStb) begin
            if (!slvBusy) begin
                slvBusy <= 1'b1;
                slvWait <= 2'(randBits(2));   // 0 to 3 wait cycles
            end else if (slvWait != 2'd0) begin
                slvWait <= slvWait - 2'd1;
            end else begin
                slvBusy <= 1'b0;
                wbAck   <= 1'b1;
                if (wbWe) begin
                    outLog.push_back({wbAdr, wbDatO});
                end else begin
                    wbDatI <= randBits(8);
                    rdLog.push_back({wbAdr, lfsr[7:0]});  // same bits just taken
                end
            end
        end
    end

    always @(negedge clk) begin
        if (slvBusy && !wbStb) begin
            errors++;
            $display("wbStb dropped before ack at %0t", $time);
        end
    end

    // **************************************************
    // checks and core control
    task checkVal(input string name, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0h exp %0h", $time, name, got, exp);
        end
    endtask

    task reportTimeout(input string what);
        errors++;
        $display("timeout at %0t waiting for %s", $time, what);
    endtask

    task resetCore;
        int n;
        @(posedge clk);
        rstReq <= 1'b1;
        @(posedge clk);
        rstReq <= 1'b0;
        @(negedge clk);                 // reset now asserted
        n = 0;
        while (!arstN && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!arstN) reportTimeout("reset release");
    endtask

    task runCore;
        int n;
        resetCore;
        n = 0;
        while (!iRead && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!iRead) begin
            reportTimeout("first fetch");
        end else begin
            checkVal("startWaitOk", int'(n >= `START_DELAY), 1);
            checkVal("iAddr", int'(iAddr), 0);
        end
        n = 0;
        while (!halted && n < 20000) begin
            @(negedge clk);
            n++;
        end
        if (!halted) reportTimeout("halted");
    endtask

    task checkOuts;
        checkVal("outCount", outLog.size(), expOut.size());
        for (int i = 0; i < outLog.size() && i < expOut.size(); i++) begin
            checkVal("wbAdr", int'(outLog[i][15:8]), int'(expOut[i][15:8]));
            checkVal("wbDatO", int'(outLog[i][7:0]), int'(expOut[i][7:0]));
        end
    endtask

    // **************************************************
    // program builder with reference model
    task loadStart;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'(i), 8'h00};    // low nibble 0 runs as NOP
        end
        for (int i = 0; i < 8; i++) begin
            regM[i] = 8'h00;
        end
        {cM, zM, nM} = 3'b000;
        pc = 0;
        expOut.delete();
        outLog.delete();
        rdLog.delete();
    endtask

    task emit(input logic [15:0] word);
        mem[pc] = word;
        pc++;
    endtask

    task modelAlu(input logic [2:0] func, input logic [2:0] rd, input logic [7:0] b);
        logic [8:0] r;
        logic [7:0] a;
        a = regM[rd];
        case (func)
            3'd1:    r = {1'b0, b};
            3'd2:    r = {1'b0, a | b};
            3'd3:    r = {1'b0, a & b};
            3'd4:    r = {1'b0, a ^ b};
            3'd5:    r = {1'b0, a} + {1'b0, b};         // carry out in bit 8
            default: r = {a < b, 8'(a - b)};             // sub and cmp borrow
        endcase
        if (func != 3'd1) begin
            {cM, zM, nM} = {r[8], r[7:0] == 8'h00, r[7]};
        end
        if (func != 3'd7) regM[rd] = r[7:0];
    endtask

    task opImm(input logic [2:0] func, input logic [2:0] rd, input logic [7:0] imm);
        emit({imm, 1'b0, rd, 1'b0, func});
        modelAlu(func, rd, imm);
    endtask

    task opReg(input logic [2:0] func, input logic [2:0] rd, input logic [2:0] rs);
        emit({1'b0, func, 1'b0, rs, 1'b0, rd, `OP_RR});
        modelAlu(func, rd, regM[rs]);
    endtask

    task writePort(input logic [2:0] rd, input logic [7:0] port);
        emit({port, 1'b0, rd, `OP_OUT});
        expOut.push_back({port, regM[rd]});
    endtask

    function automatic logic condModel(input logic [2:0] cond);
        case (cond)
            3'd1:    return cM;
            3'd2:    return !cM;
            3'd3:    return zM;
            3'd4:    return !zM;
            3'd5:    return nM;
            3'd6:    return !nM;
            default: return 1'b1;
        endcase
    endfunction

    // **************************************************
    // directed tests
    task immOpsTest;
        loadStart();
        opImm(3'd1, 3'd1, 8'h3C);
        writePort(3'd1, 8'h10);
        opImm(3'd5, 3'd1, 8'hD0);   // carry out
        writePort(3'd1, 8'h11);
        opImm(3'd6, 3'd1, 8'h20);
        writePort(3'd1, 8'h12);
        opImm(3'd3, 3'd1, 8'h0F);
        writePort(3'd1, 8'h13);
        opImm(3'd2, 3'd1, 8'hA0);
        writePort(3'd1, 8'h14);
        opImm(3'd4, 3'd1, 8'hFF);
        writePort(3'd1, 8'h15);
        for (int i = 0; i < 8; i++) begin
            opImm(3'((randBits(3) % 6) + 1), 3'(randBits(3)), randBits(8));
            writePort(3'(i), 8'h20 + 8'(i));
        end
        emit(`INSTR_HLT);
        runCore();
        checkOuts();
    endtask

    task regOpsTest;
        loadStart();
        for (int i = 0; i < 8; i++) opImm(3'd1, 3'(i), randBits(8));
        for (int f = 1; f < 8; f++) begin
            opReg(3'(f), 3'(f), 3'(f + 3));     // cmp at f 7 keeps rd
            writePort(3'(f), 8'h60 + 8'(f));
        end
        for (int i = 0; i < 8; i++) begin
            opReg(3'(randBits(3) % 7 + 1), 3'(randBits(3)), 3'(randBits(3)));
            writePort(3'(i), 8'h70 + 8'(i));
        end
        emit(`INSTR_HLT);
        runCore();
        checkOuts();
    endtask

    task branchTest;
        logic taken;
        loadStart();
        opImm(3'd1, 3'd1, 8'hA5);       // marker A
        opImm(3'd1, 3'd2, 8'hB6);       // marker B
        for (int s = 0; s < 4; s++) begin
            for (int c = 0; c < 8; c++) begin
                case (s)
                    0: begin
                        opImm(3'd1, 3'd3, 8'h05);
                        opImm(3'd7, 3'd3, 8'h05);   // Z only
                    end
                    1: begin
                        opImm(3'd1, 3'd3, 8'h05);
                        opImm(3'd7, 3'd3, 8'h09);   // C and N
                    end
                    2: begin
                        opImm(3'd1, 3'd3, 8'h05);
                        opImm(3'd7, 3'd3, 8'h01);   // all clear
                    end
                    default: begin
                        opImm(3'd1, 3'd3, 8'hF0);
                        opImm(3'd5, 3'd3, 8'h20);   // C only
                    end
                endcase
                opImm(3'd1, 3'd4, 8'h80);       // ldi must not touch flags
                taken = condModel(3'(c));
                emit({3'(c), 1'b0, 8'(pc + 3), `OP_BR});
                writePort(3'd2, 8'h30 + 8'(c));          // fall through
                if (taken) void'(expOut.pop_back());
                emit({3'd0, 1'b0, 8'(pc + 2), `OP_BR});  // skip marker A
                writePort(3'd1, 8'h30 + 8'(c));
                if (!taken) void'(expOut.pop_back());
            end
        end
        emit(`INSTR_HLT);
        runCore();
        checkOuts();
    endtask

    task ioWaitTest;
        loadStart();
        for (int i = 0; i < 6; i++) begin
            emit({8'h40 + 8'(i), 1'b0, 3'(i), `OP_IN});
            emit({8'h50 + 8'(i), 1'b0, 3'(i), `OP_OUT});   // echo back
        end
        emit(`INSTR_HLT);
        runCore();
        checkVal("inCount", rdLog.size(), 6);
        checkVal("outCount", outLog.size(), 6);
        for (int i = 0; i < 6 && i < rdLog.size() && i < outLog.size(); i++) begin
            checkVal("inAdr", int'(rdLog[i][15:8]), 8'h40 + i);
            checkVal("wbAdr", int'(outLog[i][15:8]), 8'h50 + i);
            checkVal("wbDatO", int'(outLog[i][7:0]), int'(rdLog[i][7:0]));
        end
    endtask

    task haltTest;
        loadStart();
        opImm(3'd1, 3'd0, 8'h01);
        emit(`INSTR_HLT);
        runCore();
        repeat (50) begin
            @(negedge clk);
            checkVal("halted", int'(halted), 1);
            checkVal("iRead", int'(iRead), 0);
            checkVal("wbCyc", int'(wbCyc), 0);
        end
    endtask

    initial begin
        rstReq = 1'b0;
        iData  = 16'h0000;
        wbDatI = 8'h00;
        wbAck  = 1'b0;
        errors = 0;
        checks = 0;
        immOpsTest();
        regOpsTest();
        branchTest();
        ioWaitTest();
        haltTest();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end
endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic arstN,
    input  logic rstReq
);
    logic [2:0] rstCnt = 3'd4;  // reset held for 4 cycles at time zero

    initial clk = 1'b0;
    always #4 clk = ~clk;       // 8 ns period

    always @(posedge clk) begin
        if (rstReq) begin
            rstCnt <= 3'd4;     // rerun reset on request
        end else if (rstCnt != 3'd0) begin
            rstCnt <= rstCnt - 3'd1;
        end
    end

    assign arstN = (rstCnt == 3'd0);
endmodule

/* cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic            clk,
    input  logic            arstN,
    output cpuPkg::pcT      iAddr,
    output logic            iRead,
    input  cpuPkg::instrT   iData,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output cpuPkg::ioAddrT  wbAdr,
    output cpuPkg::dataT    wbDatO,
    input  cpuPkg::dataT    wbDatI,
    input  logic            wbAck,
    output logic            halted
);
    cpuPkg::pcSelT   pcSel;
    logic            pcWriteEn;
    cpuPkg::pcT      branchTarget;
    cpuPkg::regAddrT rdAddr;
    cpuPkg::regAddrT rsAddr;
    logic            regWrEn;
    logic            regSrcIo;
    cpuPkg::aluFuncT aluFunc;
    logic            aluUseImm;
    cpuPkg::dataT    imm;
    logic            flagEn;
    logic            ioStart;
    logic            ioWrite;
    cpuPkg::ioAddrT  ioAddr;
    logic            ioDone;
    cpuPkg::dataT    ioRdData;
    cpuPkg::dataT    rdData;
    cpuPkg::dataT    rsData;
    cpuPkg::dataT    aluB;
    cpuPkg::dataT    aluResult;
    cpuPkg::dataT    regWrData;
    logic            flagC;
    logic            flagZ;
    logic            flagN;

    assign aluB      = aluUseImm ? imm : rsData;        // imm8 or rs
    assign regWrData = regSrcIo ? ioRdData : aluResult; // IN data or alu

    cpuControl u_control (.clk, .arstN, .iData, .flagC, .flagZ, .flagN, .ioDone, .iRead,
                          .pcSel, .pcWriteEn, .branchTarget, .rdAddr, .rsAddr, .regWrEn,
                          .regSrcIo, .aluFunc, .aluUseImm, .imm, .flagEn, .ioStart,
                          .ioWrite, .ioAddr, .halted);

    regFile u_regFile (.clk, .arstN, .rdAddr, .rsAddr, .wrEn(regWrEn), .wrData(regWrData),
                       .rdData, .rsData);

    aluFlags u_alu (.clk, .arstN, .a(rdData), .b(aluB), .func(aluFunc), .flagEn,
                    .result(aluResult), .flagC, .flagZ, .flagN);

    pcUnit u_pc (.clk, .arstN, .pcSel, .pcWriteEn, .target(branchTarget), .iAddr);

    // OUT sends the rd read port
    ioBusMaster u_io (.clk, .arstN, .start(ioStart), .write(ioWrite), .addr(ioAddr),
                      .wrData(rdData), .done(ioDone), .rdData(ioRdData), .wbCyc, .wbStb,
                      .wbWe, .wbAdr, .wbDatO, .wbDatI, .wbAck);
endmodule

/* cpuControl.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module cpuControl (
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::instrT   iData,
    input  logic            flagC,
    input  logic            flagZ,
    input  logic            flagN,
    input  logic            ioDone,
    output logic            iRead,
    output cpuPkg::pcSelT   pcSel,
    output logic            pcWriteEn,
    output cpuPkg::pcT      branchTarget,
    output cpuPkg::regAddrT rdAddr,
    output cpuPkg::regAddrT rsAddr,
    output logic            regWrEn,
    output logic            regSrcIo,
    output cpuPkg::aluFuncT aluFunc,
    output logic            aluUseImm,
    output cpuPkg::dataT    imm,
    output logic            flagEn,
    output logic            ioStart,
    output logic            ioWrite,
    output cpuPkg::ioAddrT  ioAddr,
    output logic            halted
);
    localparam int DelayW = $clog2(`START_DELAY + 1);

    cpuPkg::cpuStateT  state;
    cpuPkg::cpuStateT  nextState;
    logic [DelayW-1:0] delayCnt;
    logic              delayDone;
    logic [3:0]        opClass;
    logic              isRi;
    logic              isRr;
    logic              isIn;
    logic              isOut;
    logic              isBr;
    logic              isHlt;
    logic              aluSetsFlags;
    logic              condTrue;

    // **************************************************
    // state and start delay
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::stStart;
        end else begin
            state <= nextState;
        end
    end

    assign delayDone = (delayCnt == DelayW'(`START_DELAY));   // wait over

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            delayCnt <= '0;
        end else if (state == cpuPkg::stStart && !delayDone) begin
            delayCnt <= delayCnt + 1'b1;    // saturates at START_DELAY
        end
    end

    // **************************************************
    // decoder, the fetched word holds during ioWait
    assign opClass = iData[3:0];
    assign isRi    = (opClass >= 4'd1) && (opClass <= 4'd7);  // nibble is the alu func
    assign isRr    = (opClass == `OP_RR);
    assign isIn    = (opClass == `OP_IN);
    assign isOut   = (opClass == `OP_OUT);
    assign isBr    = (opClass == `OP_BR);
    assign isHlt   = (iData == `INSTR_HLT);

    assign rdAddr       = iData[6:4];
    assign rsAddr       = iData[10:8];  // rr only
    assign imm          = iData[15:8];
    assign ioAddr       = iData[15:8];  // port number
    assign ioWrite      = isOut;
    assign branchTarget = iData[11:4];
    assign aluUseImm    = isRi;
    assign halted       = (state == cpuPkg::stHalt);

    always_comb begin
        if (isRr) begin
            aluFunc = cpuPkg::aluFuncT'(iData[14:12]);
        end else if (isRi) begin
            aluFunc = cpuPkg::aluFuncT'(iData[2:0]);
        end else begin
            aluFunc = cpuPkg::aluPass;  // unused by non-alu ops
        end
    end

    // pass and LDI leave the flags alone
    assign aluSetsFlags = (aluFunc != cpuPkg::aluPass) && (aluFunc != cpuPkg::aluLdi);

    // condition table, codes 0 and 7 always
    always_comb begin
        case (iData[15:13])
            3'd1:    condTrue = flagC;
            3'd2:    condTrue = !flagC;
            3'd3:    condTrue = flagZ;
            3'd4:    condTrue = !flagZ;
            3'd5:    condTrue = flagN;
            3'd6:    condTrue = !flagN;
            default: condTrue = 1'b1;
        endcase
    end

    // **************************************************
    // control word per state
    always_comb begin
        iRead     = 1'b0;
        pcSel     = cpuPkg::pcKeep;
        pcWriteEn = 1'b0;
        regWrEn   = 1'b0;
        regSrcIo  = 1'b0;
        flagEn    = 1'b0;
        ioStart   = 1'b0;
        nextState = state;
        case (state)
            cpuPkg::stStart: begin
                if (delayDone) begin
                    iRead     = 1'b1;       // fetch address 0, pc already 0
                    nextState = cpuPkg::stExec;
                end
            end
            cpuPkg::stExec: begin
                if (isHlt) begin
                    nextState = cpuPkg::stHalt;
                end else if (isIn || isOut) begin
                    ioStart   = 1'b1;       // master latches port and data
                    nextState = cpuPkg::stIoWait;
                end else begin
                    iRead     = 1'b1;       // overlap next fetch
                    pcWriteEn = 1'b1;
                    pcSel     = (isBr && condTrue) ? cpuPkg::pcTarget : cpuPkg::pcPlusOne;
                    regWrEn   = (isRi || isRr) && (aluFunc != cpuPkg::aluCmp);
                    flagEn    = (isRi || isRr) && aluSetsFlags;
                end
            end
            cpuPkg::stIoWait: begin
                regSrcIo = 1'b1;
                if (ioDone) begin
                    regWrEn   = isIn;       // read data valid with ack
                    iRead     = 1'b1;
                    pcWriteEn = 1'b1;
                    pcSel     = cpuPkg::pcPlusOne;
                    nextState = cpuPkg::stExec;
                end
            end
            default: begin
                nextState = cpuPkg::stHalt; // only reset leaves
            end
        endcase
    end

    // pc only moves once the bus cycle has finished
    aPcHoldsInIoWait: assert property (@(posedge clk) disable iff (!arstN)
        (state == cpuPkg::stIoWait && !ioDone) |-> !pcWriteEn);

    // halt is sticky and fetches nothing
    aHaltSticky: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> halted && !iRead);
endmodule

/* ioBusMaster.sv */
`timescale 1ns/1ps

module ioBusMaster (
    input  logic           clk,
    input  logic           arstN,
    input  logic           start,
    input  logic           write,
    input  cpuPkg::ioAddrT addr,
    input  cpuPkg::dataT   wrData,
    output logic           done,
    output cpuPkg::dataT   rdData,
    output logic           wbCyc,
    output logic           wbStb,
    output logic           wbWe,
    output cpuPkg::ioAddrT wbAdr,
    output cpuPkg::dataT   wbDatO,
    input  cpuPkg::dataT   wbDatI,
    input  logic           wbAck
);
    logic launch;

    assign launch = start && !wbCyc;    // one cycle at a time
    assign done   = wbCyc && wbAck;     // stray acks ignored
    assign rdData = wbDatI;             // valid in the ack cycle only

    // **************************************************
    // classic cycle held until ack
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbCyc <= 1'b0;
            wbStb <= 1'b0;
            wbWe  <= 1'b0;
        end else if (done) begin
            wbCyc <= 1'b0;  // drop the cycle after ack
            wbStb <= 1'b0;
        end else if (launch) begin
            wbCyc <= 1'b1;
            wbStb <= 1'b1;
            wbWe  <= write;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAdr  <= '0;
            wbDatO <= '0;
        end else if (launch) begin
            wbAdr  <= addr;
            wbDatO <= wrData;   // rd value at exec
        end
    end

    aStbNeedsCyc: assert property (@(posedge clk) disable iff (!arstN)
        $rose(wbStb) |-> wbCyc);

    // request stays put until the slave answers
    aHoldUntilAck: assert property (@(posedge clk) disable iff (!arstN)
        (wbStb && !wbAck) |=> wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatO));
endmodule

/* pcUnit.sv */
`timescale 1ns/1ps

module pcUnit (
    input  logic          clk,
    input  logic          arstN,
    input  cpuPkg::pcSelT pcSel,
    input  logic          pcWriteEn,
    input  cpuPkg::pcT    target,
    output cpuPkg::pcT    iAddr
);
    cpuPkg::pcT pcQ;        // address of the word in exec
    cpuPkg::pcT nextPc;

    // **************************************************
    // next fetch address
    always_comb begin
        case (pcSel)
            cpuPkg::pcPlusOne: nextPc = pcQ + cpuPkg::pcT'(1);  // wraps at 255
            cpuPkg::pcTarget:  nextPc = target;                 // no delay slot
            default:           nextPc = pcQ;
        endcase
    end

    assign iAddr = nextPc;  // memory sees the address being loaded

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcQ <= '0;
        end else if (pcWriteEn) begin
            pcQ <= nextPc;
        end
    end
endmodule

/* aluFlags.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module aluFlags (
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::dataT    a,
    input  cpuPkg::dataT    b,
    input  cpuPkg::aluFuncT func,
    input  logic            flagEn,
    output cpuPkg::dataT    result,
    output logic            flagC,
    output logic            flagZ,
    output logic            flagN
);
    logic [`DATA_W:0] addExt;   // msb is carry out
    logic [`DATA_W:0] subExt;   // msb is borrow, a < b unsigned
    logic             carryNew;

    assign addExt = {1'b0, a} + {1'b0, b};
    assign subExt = {1'b0, a} - {1'b0, b};

    // **************************************************
    // function select
    always_comb begin
        carryNew = 1'b0;    // logic ops clear carry
        case (func)
            cpuPkg::aluPass: result = a;
            cpuPkg::aluLdi:  result = b;
            cpuPkg::aluOr:   result = a | b;
            cpuPkg::aluAnd:  result = a & b;
            cpuPkg::aluXor:  result = a ^ b;
            cpuPkg::aluAdd: begin
                result   = addExt[`DATA_W-1:0];
                carryNew = addExt[`DATA_W];
            end
            cpuPkg::aluSub, cpuPkg::aluCmp: begin
                result   = subExt[`DATA_W-1:0];
                carryNew = subExt[`DATA_W];
            end
            default: result = a;
        endcase
    end

    // flags only move on flag-setting ops
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flagC <= 1'b0;
            flagZ <= 1'b0;
            flagN <= 1'b0;
        end else if (flagEn) begin
            flagC <= carryNew;
            flagZ <= (result == '0);
            flagN <= result[`DATA_W-1];     // sign bit
        end
    end
endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module regFile (
    input  logic            clk,
    input  logic            arstN,
    input  cpuPkg::regAddrT rdAddr,
    input  cpuPkg::regAddrT rsAddr,
    input  logic            wrEn,
    input  cpuPkg::dataT    wrData,
    output cpuPkg::dataT    rdData,
    output cpuPkg::dataT    rsData
);
    cpuPkg::dataT regs [`REG_COUNT];

    // single write port, always to rd
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[rdAddr] <= wrData;
        end
    end

    // **************************************************
    // combinational reads
    assign rdData = regs[rdAddr];   // alu a, OUT data
    assign rsData = regs[rsAddr];   // alu b for rr

endmodule

/* cpuPkg.sv */
`include "cpuParams.svh"

package cpuPkg;

    // **************************************************
    // width types
    typedef logic [`DATA_W-1:0]     dataT;      // data path
    typedef logic [`INSTR_W-1:0]    instrT;     // fetched word
    typedef logic [`PC_W-1:0]       pcT;        // fetch address
    typedef logic [`REG_ADDR_W-1:0] regAddrT;   // register index
    typedef logic [`IO_ADDR_W-1:0]  ioAddrT;    // port number

    // alu functions, same code as the low nibble of an r-i op
    typedef enum logic [2:0] {
        aluPass = 3'd0,     // result = a
        aluLdi  = 3'd1,     // result = b
        aluOr   = 3'd2,
        aluAnd  = 3'd3,
        aluXor  = 3'd4,
        aluAdd  = 3'd5,
        aluSub  = 3'd6,
        aluCmp  = 3'd7      // sub without writeback
    } aluFuncT;

    // next fetch address select
    typedef enum logic [1:0] {
        pcKeep,             // current pc
        pcPlusOne,          // sequential
        pcTarget            // taken branch
    } pcSelT;

    // control fsm
    typedef enum logic [2:0] {
        stStart,            // counted wait after reset
        stExec,             // decode and run fetched word
        stIoWait,           // bus cycle in flight
        stHalt              // parked until reset
    } cpuStateT;

endpackage

/* cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// **************************************************
// core widths
`define DATA_W      8       // register, alu and bus data
`define INSTR_W     16      // one instruction word
`define PC_W        8       // instruction address
`define REG_ADDR_W  3       // register index
`define IO_ADDR_W   8       // port address

// **************************************************
// core sizing and timing
`define REG_COUNT   8       // general purpose registers
`define START_DELAY 40      // cycles in start before first fetch

// **************************************************
// instruction classes, low nibble
`define OP_IN       4'd8    // rd <- port
`define OP_OUT      4'd9    // port <- rd
`define OP_RR       4'd10   // register-register alu op
`define OP_BR       4'd14   // conditional branch, one word
`define INSTR_HLT   16'hFFFF // halt until reset

`endif
